// File: sa_array.sv
`timescale 1ns/1ps

module sa_array #(
  parameter int SIZE   = sa_cfg_pkg::SIZE,
  parameter int DATA_W = sa_cfg_pkg::DATA_W,
  parameter int ACC_W  = sa_cfg_pkg::ACC_W
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         en,
  input  logic [SIZE-1:0][DATA_W-1:0]  x_lane,
  input  logic [SIZE-1:0][DATA_W-1:0]  w_lane,
  input  logic [SIZE-1:0]              x_ren,
  input  logic [SIZE-1:0]              w_ren,
  output logic [SIZE*SIZE*ACC_W-1:0]   result
);

  logic [SIZE-1:0][DATA_W-1:0] x_edge;
  logic [SIZE-1:0][DATA_W-1:0] w_edge;
  logic [DATA_W-1:0]           x_fwd [SIZE][SIZE];
  logic [DATA_W-1:0]           w_fwd [SIZE][SIZE];

  // idle lanes feed zero so the cells add nothing
  always_comb begin
    for (int i = 0; i < SIZE; i++) begin
      x_edge[i] = x_ren[i] ? x_lane[i] : '0;
      w_edge[i] = w_ren[i] ? w_lane[i] : '0;
    end
  end

  for (genvar i = 0; i < SIZE; i++) begin : g_row
    for (genvar j = 0; j < SIZE; j++) begin : g_col
      logic [DATA_W-1:0] x_in;
      logic [DATA_W-1:0] w_in;

      if (j == 0) begin : g_x_edge
        assign x_in = x_edge[i];
      end else begin : g_x_chain
        assign x_in = x_fwd[i][j-1];
      end

      if (i == 0) begin : g_w_edge
        assign w_in = w_edge[j];
      end else begin : g_w_chain
        assign w_in = w_fwd[i-1][j];
      end

      sa_pe #(
        .DATA_W(DATA_W),
        .ACC_W (ACC_W)
      ) pe_i (
        .clk  (clk),
        .rst  (rst),
        .en   (en),
        .x_in (x_in),
        .w_in (w_in),
        .x_out(x_fwd[i][j]),
        .w_out(w_fwd[i][j]),
        .acc  (result[(i*SIZE+j)*ACC_W +: ACC_W]) // row-major
      );
    end
  end

endmodule

// File: sa_assertions.sv
`timescale 1ns/1ps

module sa_assertions #(
  parameter int SIZE = sa_cfg_pkg::SIZE
) (
  input logic                      clk,
  input logic                      rst,
  input sa_types_pkg::ctrl_state_e state,
  input logic [SIZE-1:0]           ren,
  input logic                      x_send_rdy,
  input logic                      w_send_rdy,
  input logic                      done
);

  int fail_count = 0; // failed assertion attempts

  state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else begin
      fail_count++;
      $error("controller state is not one-hot");
    end

  rdy_only_in_load: assert property (@(posedge clk) disable iff (rst)
    (x_send_rdy || w_send_rdy) |-> (state == sa_types_pkg::LOAD))
    else begin
      fail_count++;
      $error("send rdy high outside LOAD");
    end

  done_sticky: assert property (@(posedge clk) disable iff (rst) done |=> done)
    else begin
      fail_count++;
      $error("done fell without a reset");
    end

  // lane i follows lane i-1 by one cycle
  for (genvar i = 1; i < SIZE; i++) begin : g_skew
    ren_skew: assert property (@(posedge clk) disable iff (rst)
      (state == sa_types_pkg::MAC) |=> (ren[i] == $past(ren[i-1])))
      else begin
        fail_count++;
        $error("read enable skew broken on lane %0d", i);
      end
  end

endmodule

bind sa_ctrl sa_assertions #(.SIZE(SIZE)) assertions_i (
  .clk       (clk),
  .rst       (rst),
  .state     (state),
  .ren       (ren),
  .x_send_rdy(x_send_rdy),
  .w_send_rdy(w_send_rdy),
  .done      (done)
);

// File: sa_cfg_pkg.sv
package sa_cfg_pkg;

  // array edge, also the FIFO depth and the number of lanes per stream
  parameter int SIZE = 4;

  // operand width in bits
  parameter int DATA_W = 8;

  // accumulator width in bits; holds SIZE unsigned products of two DATA_W operands
  parameter int ACC_W = 20;

endpackage

// File: sa_ctrl.sv
`timescale 1ns/1ps

module sa_ctrl #(
  parameter int SIZE = sa_cfg_pkg::SIZE
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  x_send_val,
  output logic                                  x_send_rdy,
  input  logic                                  w_send_val,
  output logic                                  w_send_rdy,
  input  sa_types_pkg::fifo_status_t [SIZE-1:0] x_status,
  input  sa_types_pkg::fifo_status_t [SIZE-1:0] w_status,
  output sa_types_pkg::fifo_cmd_t    [SIZE-1:0] x_cmd,
  output sa_types_pkg::fifo_cmd_t    [SIZE-1:0] w_cmd,
  output logic                                  mac_en,
  output logic                                  done
);

  localparam int CNT_W = $clog2(2 * SIZE + 1);

  sa_types_pkg::ctrl_state_e state;

  logic             x_full;
  logic             w_full;
  logic             all_full;
  logic             all_empty;
  logic             lane0_next;
  logic [SIZE-1:0]  ren;
  logic [CNT_W-1:0] cnt;

  always_comb begin
    x_full    = 1'b1;
    w_full    = 1'b1;
    all_empty = 1'b1;
    for (int i = 0; i < SIZE; i++) begin
      x_full    = x_full & x_status[i].full;
      w_full    = w_full & w_status[i].full;
      all_empty = all_empty & x_status[i].empty & w_status[i].empty;
    end
  end

  assign all_full = x_full & w_full;

  // cnt counts MAC cycles for the lane 0 window, then the drain cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= sa_types_pkg::LOAD;
      cnt   <= '0;
    end else begin
      case (state)
        sa_types_pkg::LOAD: begin
          if (all_full) begin
            state <= sa_types_pkg::MAC;
            cnt   <= '0;
          end
        end
        sa_types_pkg::MAC: begin
          if (all_empty) begin
            state <= sa_types_pkg::DRAIN;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        sa_types_pkg::DRAIN: begin
          if (cnt == CNT_W'(2 * SIZE - 1)) begin
            state <= sa_types_pkg::DONE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        sa_types_pkg::DONE: state <= sa_types_pkg::DONE; // held until reset
        default: state <= sa_types_pkg::LOAD;
      endcase
    end
  end

  // lane 0 reads for exactly SIZE cycles, starting in the first MAC cycle
  assign lane0_next = ((state == sa_types_pkg::LOAD) & all_full) |
                      ((state == sa_types_pkg::MAC) & ~all_empty &
                       (cnt < CNT_W'(SIZE - 1)));

  always_ff @(posedge clk) begin
    if (rst) begin
      ren <= '0;
    end else begin
      ren[0] <= lane0_next;
      for (int i = 1; i < SIZE; i++) begin
        ren[i] <= (state == sa_types_pkg::MAC) & ren[i-1]; // one cycle skew per lane
      end
    end
  end

  assign x_send_rdy = (state == sa_types_pkg::LOAD) & x_send_val & ~x_full;
  assign w_send_rdy = (state == sa_types_pkg::LOAD) & w_send_val & ~w_full;

  always_comb begin
    for (int i = 0; i < SIZE; i++) begin
      x_cmd[i].wen = x_send_rdy;
      x_cmd[i].ren = ren[i];
      w_cmd[i].wen = w_send_rdy;
      w_cmd[i].ren = ren[i];
    end
  end

  assign mac_en = (state == sa_types_pkg::MAC) | (state == sa_types_pkg::DRAIN);
  assign done   = (state == sa_types_pkg::DONE);

endmodule

// File: sa_operand_fifo.sv
`timescale 1ns/1ps

module sa_operand_fifo #(
  parameter int DATA_W = sa_cfg_pkg::DATA_W,
  parameter int DEPTH  = sa_cfg_pkg::SIZE
) (
  input  logic                      clk,
  input  logic                      rst,
  input  sa_types_pkg::fifo_cmd_t    cmd,
  input  logic [DATA_W-1:0]         wdata,
  output logic [DATA_W-1:0]         rdata,
  output sa_types_pkg::fifo_status_t status
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1; // wrap at DEPTH
  endfunction

  always_ff @(posedge clk) begin
    if (cmd.wen) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd.wen) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (cmd.ren) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({cmd.wen, cmd.ren})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // idle or simultaneous push and pop
      endcase
    end
  end

  assign rdata        = mem[rd_ptr]; // head visible without a read cycle
  assign status.full  = (count == CNT_W'(DEPTH));
  assign status.empty = (count == '0);

endmodule

// File: sa_pe.sv
`timescale 1ns/1ps

module sa_pe #(
  parameter int DATA_W = sa_cfg_pkg::DATA_W,
  parameter int ACC_W  = sa_cfg_pkg::ACC_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              en,
  input  logic [DATA_W-1:0] x_in,
  input  logic [DATA_W-1:0] w_in,
  output logic [DATA_W-1:0] x_out,
  output logic [DATA_W-1:0] w_out,
  output logic [ACC_W-1:0]  acc
);

  logic [2*DATA_W-1:0] prod;

  assign prod = x_in * w_in; // unsigned

  always_ff @(posedge clk) begin
    if (rst) begin
      x_out <= '0;
      w_out <= '0;
      acc   <= '0;
    end else if (en) begin
      x_out <= x_in;  // moves right next cycle
      w_out <= w_in;  // moves down next cycle
      acc   <= acc + ACC_W'(prod);
    end
  end

endmodule

// File: sa_top.sv
`timescale 1ns/1ps

module sa_top #(
  parameter int SIZE   = sa_cfg_pkg::SIZE,
  parameter int DATA_W = sa_cfg_pkg::DATA_W,
  parameter int ACC_W  = sa_cfg_pkg::ACC_W
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       x_send_val,
  output logic                       x_send_rdy,
  input  logic [SIZE*DATA_W-1:0]     x_data,
  input  logic                       w_send_val,
  output logic                       w_send_rdy,
  input  logic [SIZE*DATA_W-1:0]     w_data,
  output logic [SIZE*SIZE*ACC_W-1:0] result,
  output logic                       done
);

  sa_types_pkg::fifo_status_t [SIZE-1:0] x_status;
  sa_types_pkg::fifo_status_t [SIZE-1:0] w_status;
  sa_types_pkg::fifo_cmd_t    [SIZE-1:0] x_cmd;
  sa_types_pkg::fifo_cmd_t    [SIZE-1:0] w_cmd;
  logic [SIZE-1:0][DATA_W-1:0]          x_lane;
  logic [SIZE-1:0][DATA_W-1:0]          w_lane;
  logic [SIZE-1:0]                      x_ren;
  logic [SIZE-1:0]                      w_ren;
  logic                                 mac_en;

  sa_ctrl #(
    .SIZE(SIZE)
  ) ctrl_i (
    .clk       (clk),
    .rst       (rst),
    .x_send_val(x_send_val),
    .x_send_rdy(x_send_rdy),
    .w_send_val(w_send_val),
    .w_send_rdy(w_send_rdy),
    .x_status  (x_status),
    .w_status  (w_status),
    .x_cmd     (x_cmd),
    .w_cmd     (w_cmd),
    .mac_en    (mac_en),
    .done      (done)
  );

  // one row FIFO and one column FIFO per lane
  for (genvar i = 0; i < SIZE; i++) begin : g_lane
    sa_operand_fifo #(.DATA_W(DATA_W), .DEPTH(SIZE)) x_fifo_i (
      .clk   (clk),
      .rst   (rst),
      .cmd   (x_cmd[i]),
      .wdata (x_data[i*DATA_W +: DATA_W]),
      .rdata (x_lane[i]),
      .status(x_status[i])
    );

    sa_operand_fifo #(.DATA_W(DATA_W), .DEPTH(SIZE)) w_fifo_i (
      .clk   (clk),
      .rst   (rst),
      .cmd   (w_cmd[i]),
      .wdata (w_data[i*DATA_W +: DATA_W]),
      .rdata (w_lane[i]),
      .status(w_status[i])
    );

    assign x_ren[i] = x_cmd[i].ren;
    assign w_ren[i] = w_cmd[i].ren;
  end

  sa_array #(
    .SIZE  (SIZE),
    .DATA_W(DATA_W),
    .ACC_W (ACC_W)
  ) array_i (
    .clk   (clk),
    .rst   (rst),
    .en    (mac_en),
    .x_lane(x_lane),
    .w_lane(w_lane),
    .x_ren (x_ren),
    .w_ren (w_ren),
    .result(result)
  );

endmodule

// File: sa_types_pkg.sv
package sa_types_pkg;

  // one-hot controller states
  typedef enum logic [3:0] {
    LOAD  = 4'b0001,
    MAC   = 4'b0010,
    DRAIN = 4'b0100,
    DONE  = 4'b1000
  } ctrl_state_e;

  // flags reported by each operand FIFO
  typedef struct packed {
    logic full;
    logic empty;
  } fifo_status_t;

  // enables sent to each operand FIFO
  typedef struct packed {
    logic wen;
    logic ren;
  } fifo_cmd_t;

endpackage

// File: tb_sa_top.sv
`timescale 1ns/1ps

module tb_sa_top;

  localparam int SIZE          = sa_cfg_pkg::SIZE;
  localparam int DATA_W        = sa_cfg_pkg::DATA_W;
  localparam int ACC_W         = sa_cfg_pkg::ACC_W;
  localparam int BEAT_TIMEOUT  = 20;
  localparam int DONE_TIMEOUT  = 100;

  logic                       clk;
  logic                       rst;
  logic                       x_send_val;
  logic                       x_send_rdy;
  logic [SIZE*DATA_W-1:0]     x_data;
  logic                       w_send_val;
  logic                       w_send_rdy;
  logic [SIZE*DATA_W-1:0]     w_data;
  logic [SIZE*SIZE*ACC_W-1:0] result;
  logic                       done;

  logic [DATA_W-1:0] xm    [SIZE][SIZE];
  logic [DATA_W-1:0] wm    [SIZE][SIZE];
  logic [ACC_W-1:0]  exp_m [SIZE][SIZE];
  logic [31:0]       lcg_state;
  int                error_count;
  int                tests_run;
  int                tests_failed;

  sa_top #(.SIZE(SIZE), .DATA_W(DATA_W), .ACC_W(ACC_W)) dut_i (
    .clk       (clk),
    .rst       (rst),
    .x_send_val(x_send_val),
    .x_send_rdy(x_send_rdy),
    .x_data    (x_data),
    .w_send_val(w_send_val),
    .w_send_rdy(w_send_rdy),
    .w_data    (w_data),
    .result    (result),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  function automatic logic [DATA_W-1:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return DATA_W'(lcg_state >> 16);
  endfunction

  task automatic apply_reset();
    rst        = 1'b1;
    x_send_val = 1'b0;
    w_send_val = 1'b0;
    x_data     = '0;
    w_data     = '0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  // beat k of X is column k, beat k of W is row k
  task automatic send_stream(input bit is_w);
    logic [SIZE*DATA_W-1:0] beat;
    bit                     accepted;
    int                     cycles;
    for (int k = 0; k < SIZE; k++) begin
      for (int i = 0; i < SIZE; i++) begin
        beat[i*DATA_W +: DATA_W] = is_w ? wm[k][i] : xm[i][k];
      end
      if (is_w) begin
        w_send_val = 1'b1;
        w_data     = beat;
      end else begin
        x_send_val = 1'b1;
        x_data     = beat;
      end
      accepted = 1'b0;
      cycles   = 0;
      while (!accepted && cycles < BEAT_TIMEOUT) begin
        @(negedge clk);
        accepted = is_w ? w_send_rdy : x_send_rdy; // transfers at the coming edge
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!accepted) begin
        $display("Error at %0t: beat %0d of the %s stream was never accepted",
                 $time, k, is_w ? "W" : "X");
        error_count++;
      end
    end
    if (is_w) begin
      w_send_val = 1'b0;
    end else begin
      x_send_val = 1'b0;
    end
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!done && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      $display("Error at %0t: timed out waiting for done", $time);
      error_count++;
    end
  endtask

  // software matrix product
  task automatic compute_product();
    longint sum;
    for (int i = 0; i < SIZE; i++) begin
      for (int j = 0; j < SIZE; j++) begin
        sum = 0;
        for (int k = 0; k < SIZE; k++) begin
          sum += longint'(xm[i][k]) * longint'(wm[k][j]);
        end
        exp_m[i][j] = ACC_W'(sum);
      end
    end
  endtask

  task automatic check_result();
    logic [ACC_W-1:0] got;
    for (int i = 0; i < SIZE; i++) begin
      for (int j = 0; j < SIZE; j++) begin
        got = result[(i*SIZE+j)*ACC_W +: ACC_W];
        if (got !== exp_m[i][j]) begin
          $display("Mismatch at %0t: result[%0d][%0d] is %0d, expected %0d",
                   $time, i, j, got, exp_m[i][j]);
          error_count++;
        end
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count > errors_before) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - errors_before);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < SIZE; i++) begin
      for (int k = 0; k < SIZE; k++) begin
        xm[i][k] = next_random();
        wm[i][k] = next_random();
      end
    end
  endtask

  task automatic test_reset_state();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    repeat (3) begin
      @(negedge clk);
      if (done !== 1'b0 || x_send_rdy !== 1'b0 || w_send_rdy !== 1'b0) begin
        $display("Mismatch at %0t: after reset done=%b x_rdy=%b w_rdy=%b, expected all 0",
                 $time, done, x_send_rdy, w_send_rdy);
        error_count++;
      end
    end
    @(posedge clk);
    #1;
    finish_test("reset state", errors_before);
  endtask

  task automatic test_identity();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    for (int i = 0; i < SIZE; i++) begin
      for (int k = 0; k < SIZE; k++) begin
        xm[i][k] = DATA_W'(i * 16 + k * 3 + 1);
        wm[i][k] = (i == k) ? DATA_W'(1) : '0;
        exp_m[i][k] = ACC_W'(xm[i][k]); // identity leaves X unchanged
      end
    end
    fork
      send_stream(1'b0);
      send_stream(1'b1);
    join
    wait_done();
    check_result();
    finish_test("identity", errors_before);
  endtask

  task automatic test_random(input string name);
    int errors_before;
    errors_before = error_count;
    apply_reset();
    fill_random();
    compute_product();
    fork
      send_stream(1'b0);
      send_stream(1'b1);
    join
    wait_done();
    check_result();
    finish_test(name, errors_before);
  endtask

  task automatic test_x_before_w();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    fill_random();
    compute_product();
    send_stream(1'b0);
    x_send_val = 1'b1; // extra beat offered to a full X stream
    x_data     = '1;
    repeat (5) begin
      @(negedge clk);
      if (x_send_rdy !== 1'b0) begin
        $display("Mismatch at %0t: x_send_rdy is 1 with X full, expected 0", $time);
        error_count++;
      end
      @(posedge clk);
      #1;
    end
    x_send_val = 1'b0;
    send_stream(1'b1);
    wait_done();
    check_result();
    finish_test("x before w", errors_before);
  endtask

  task automatic test_done_hold();
    int                         errors_before;
    logic [SIZE*SIZE*ACC_W-1:0] snapshot;
    errors_before = error_count;
    apply_reset();
    fill_random();
    compute_product();
    fork
      send_stream(1'b0);
      send_stream(1'b1);
    join
    wait_done();
    check_result();
    snapshot = result;
    repeat (20) begin
      x_send_val = 1'b1;
      w_send_val = 1'b1;
      x_data     = {next_random(), next_random(), next_random(), next_random()};
      w_data     = {next_random(), next_random(), next_random(), next_random()};
      @(negedge clk);
      if (done !== 1'b1 || result !== snapshot) begin
        $display("Mismatch at %0t: done=%b or result changed after done", $time, done);
        error_count++;
      end
      if (x_send_rdy !== 1'b0 || w_send_rdy !== 1'b0) begin
        $display("Mismatch at %0t: rdy high in DONE, x=%b w=%b", $time, x_send_rdy,
                 w_send_rdy);
        error_count++;
      end
      @(posedge clk);
      #1;
    end
    x_send_val = 1'b0;
    w_send_val = 1'b0;
    finish_test("done hold", errors_before);
  endtask

  task automatic test_max_operands();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    for (int i = 0; i < SIZE; i++) begin
      for (int k = 0; k < SIZE; k++) begin
        xm[i][k]    = '1;
        wm[i][k]    = '1;
        exp_m[i][k] = ACC_W'(SIZE * ((2 ** DATA_W - 1) ** 2));
      end
    end
    fork
      send_stream(1'b0);
      send_stream(1'b1);
    join
    wait_done();
    check_result();
    finish_test("max operands", errors_before);
  endtask

  initial begin
    rst          = 1'b1;
    x_send_val   = 1'b0;
    w_send_val   = 1'b0;
    x_data       = '0;
    w_data       = '0;
    lcg_state    = 32'd66;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_reset_state();
    test_identity();
    test_random("random 1");
    test_random("random 2");
    test_x_before_w();
    test_done_hold();
    test_max_operands();
    if (dut_i.ctrl_i.assertions_i.fail_count != 0) begin
      $display("Error: %0d controller assertion failures",
               dut_i.ctrl_i.assertions_i.fail_count);
      error_count += dut_i.ctrl_i.assertions_i.fail_count;
    end
    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
sa_cfg_pkg.sv
sa_types_pkg.sv
sa_operand_fifo.sv
sa_ctrl.sv
sa_pe.sv
sa_array.sv
sa_top.sv
sa_assertions.sv
tb_sa_top.sv
